// ==== ring_pkg.sv ====
// ring_pkg
// shared widths, frame codes, flit layout and register map for the flit ring node
package ring_pkg;

  localparam int flit_w    = 16;               // one ring word
  localparam int ctrl_w    = 2;                // frame code
  localparam int node_id_w = 4;
  localparam int chan_w    = 2;                // dest_fifo code on the ring
  localparam int entry_w   = ctrl_w + flit_w;  // what every fifo stores
  localparam int adr_w     = 3;                // wishbone word address
  localparam int reg_w     = 32;               // wishbone data width

  // frame codes carried beside each flit
  localparam logic [ctrl_w-1:0] ctrl_none = 2'b00;
  localparam logic [ctrl_w-1:0] ctrl_head = 2'b01;
  localparam logic [ctrl_w-1:0] ctrl_body = 2'b10;
  localparam logic [ctrl_w-1:0] ctrl_tail = 2'b11;

  // channel tags on dest_fifo, anything else is dropped at the input
  localparam logic [chan_w-1:0] chan_req = 2'b01;
  localparam logic [chan_w-1:0] chan_rep = 2'b10;

  // host register map
  localparam logic [adr_w-1:0] reg_rx_req = 3'd0;
  localparam logic [adr_w-1:0] reg_rx_rep = 3'd1;
  localparam logic [adr_w-1:0] reg_tx_req = 3'd2;
  localparam logic [adr_w-1:0] reg_tx_rep = 3'd3;
  localparam logic [adr_w-1:0] reg_status = 3'd4;

  // a flit read as a head (routing fields) or as plain payload
  typedef union packed {
    struct packed {
      logic [node_id_w-1:0]          dest;  // target node
      logic [node_id_w-1:0]          src;   // sending node
      logic [flit_w-2*node_id_w-1:0] tag;   // message kind / sequence
    } head;
    struct packed {
      logic [flit_w-1:0] data;
    } body;
  } flit_u;

endpackage

// ==== ring_ifs.sv ====
`timescale 1ns/100ps
// ring node internal links
// flit_link_if carries one channel toward the link arbiter,
// host_chan_if joins the register block to one channel's host fifos
interface flit_link_if import ring_pkg::*; ();
  logic [entry_w-1:0] entry;  // frame code + flit
  logic               valid;
  logic               take;   // flit moves when valid && take

  modport src (
    output entry,
    output valid,
    input  take
  );

  modport sink (
    input  entry,
    input  valid,
    output take
  );
endinterface

interface host_chan_if import ring_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) ();
  logic [entry_w-1:0]              rx_entry;  // head of receive fifo
  logic                            rx_valid;
  logic [$clog2(FIFO_DEPTH+1)-1:0] rx_count;
  logic                            rx_pop;    // only with rx_valid
  logic [entry_w-1:0]              tx_entry;
  logic                            tx_push;   // only with !tx_full
  logic                            tx_full;

  modport regs (
    input  rx_entry, rx_valid, rx_count, tx_full,
    output rx_pop, tx_entry, tx_push
  );

  modport chan (
    output rx_entry, rx_valid, rx_count, tx_full,
    input  rx_pop, tx_entry, tx_push
  );
endinterface

// ==== flit_fifo.sv ====
`timescale 1ns/100ps
// flit_fifo
// circular buffer of frame-plus-flit entries, head word falls through
module flit_fifo import ring_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            push,
  input  logic [entry_w-1:0]              push_entry,
  input  logic                            pop,
  output logic [entry_w-1:0]              head_entry,
  output logic                            empty,
  output logic                            full,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] count
);
  localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

  logic [entry_w-1:0] mem [FIFO_DEPTH];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic               do_push;
  logic               do_pop;

  assign do_push    = push && !full;   // overflow is dropped
  assign do_pop     = pop && !empty;
  assign empty      = (count == '0);
  assign full       = (count == cnt_w'(FIFO_DEPTH));
  assign head_entry = mem[rd_ptr];     // fwft

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // depth need not be 2^n
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end
endmodule

// ==== ring_channel.sv ====
`timescale 1ns/100ps
// ring_channel
// one ring channel: routes arriving packets to the local receive fifo or the pass fifo,
// then merges pass traffic with host transmit packets, whole packets at a time
module ring_channel import ring_pkg::*; #(
  parameter int NODE_ID    = 0,
  parameter int FIFO_DEPTH = 8
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,  // flit for this channel present on the ring
  input  logic [entry_w-1:0] in_entry,
  output logic               in_ready,  // en_pass_* toward upstream
  host_chan_if.chan          host,
  flit_link_if.src           link
);
  flit_u              in_flit;
  logic               is_head;
  logic               head_hit;    // head addressed to this node
  logic               route_local; // route held for body and tail
  logic               to_local;
  logic               pass_full;
  logic               pass_empty;
  logic [entry_w-1:0] pass_head;
  logic               rx_empty;
  logic               rx_full;
  logic               tx_empty;
  logic [entry_w-1:0] tx_head;
  logic               merge_busy;  // mid-packet on the link
  logic               merge_tx;    // source of that packet
  logic               use_tx;
  logic               fire;

  assign in_flit.body.data = in_entry[flit_w-1:0];
  assign is_head  = (in_entry[entry_w-1 -: ctrl_w] == ctrl_head);
  assign head_hit = (in_flit.head.dest == node_id_w'(NODE_ID));
  assign to_local = is_head ? head_hit : route_local;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      route_local <= 1'b0;
    end else if (in_valid && is_head) begin
      route_local <= head_hit;  // latched per packet
    end
  end

  assign in_ready = !pass_full && !rx_full;  // room on either route

  flit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) pass_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(in_valid && !to_local), .push_entry(in_entry),
    .pop(fire && !use_tx),
    .head_entry(pass_head), .empty(pass_empty), .full(pass_full), .count()
  );

  flit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(in_valid && to_local), .push_entry(in_entry),
    .pop(host.rx_pop),
    .head_entry(host.rx_entry), .empty(rx_empty), .full(rx_full), .count(host.rx_count)
  );
  assign host.rx_valid = !rx_empty;

  flit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(host.tx_push), .push_entry(host.tx_entry),
    .pop(fire && use_tx),
    .head_entry(tx_head), .empty(tx_empty), .full(host.tx_full), .count()
  );

  // merge: pass traffic first, choice held until the tail leaves
  assign use_tx     = merge_busy ? merge_tx : pass_empty;
  assign link.valid = use_tx ? !tx_empty : !pass_empty;
  assign link.entry = use_tx ? tx_head : pass_head;
  assign fire       = link.valid && link.take;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      merge_busy <= 1'b0;
      merge_tx   <= 1'b0;
    end else if (fire) begin
      merge_busy <= (link.entry[entry_w-1 -: ctrl_w] != ctrl_tail);  // free after tail
      merge_tx   <= use_tx;
    end
  end
endmodule

// ==== link_arbiter.sv ====
`timescale 1ns/100ps
// link_arbiter
// registered output stage merging the request and reply channels onto the ring,
// reply first, grant held for a whole packet
module link_arbiter import ring_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_ready,  // en_pass_req_in from downstream
  input  logic              rep_ready,  // en_pass_rep_in from downstream
  flit_link_if.sink         req,
  flit_link_if.sink         rep,
  output logic [ctrl_w-1:0] ctrl_out,
  output logic [flit_w-1:0] flit_out,
  output logic [chan_w-1:0] dest_fifo_out
);
  logic               grant_busy;  // packet in flight
  logic               grant_rep;
  logic               cur_rep;     // channel granted this cycle
  logic               out_valid;
  logic               out_rep;
  logic [entry_w-1:0] out_entry;
  logic               sent;
  logic               can_load;
  logic               fire_req;
  logic               fire_rep;

  assign cur_rep  = grant_busy ? grant_rep : rep.valid;  // reply wins a fresh grant
  assign sent     = out_valid && (out_rep ? rep_ready : req_ready);
  assign can_load = !out_valid || sent;
  assign req.take = can_load && !cur_rep && req_ready;
  assign rep.take = can_load && cur_rep && rep_ready;
  assign fire_req = req.valid && req.take;
  assign fire_rep = rep.valid && rep.take;

  // flit shows only while downstream can take it, otherwise held in out_entry
  assign ctrl_out      = sent ? out_entry[entry_w-1 -: ctrl_w] : ctrl_none;
  assign flit_out      = out_entry[flit_w-1:0];
  assign dest_fifo_out = out_rep ? chan_rep : chan_req;  // steady across a packet

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      grant_busy <= 1'b0;
      grant_rep  <= 1'b0;
      out_valid  <= 1'b0;
      out_rep    <= 1'b0;
    end else if (fire_req || fire_rep) begin
      grant_busy <= (cur_rep ? rep.entry[entry_w-1 -: ctrl_w]
                             : req.entry[entry_w-1 -: ctrl_w]) != ctrl_tail;
      grant_rep  <= cur_rep;
      out_valid  <= 1'b1;
      out_rep    <= cur_rep;
    end else if (sent) begin
      out_valid  <= 1'b0;  // drained, nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (fire_req || fire_rep) begin
      out_entry <= cur_rep ? rep.entry : req.entry;
    end
  end
endmodule

// ==== node_regs.sv ====
`timescale 1ns/100ps
// node_regs
// wishbone classic slave, no wait states; pops the receive fifos,
// pushes the transmit fifos and reports fifo status
module node_regs import ring_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  logic [adr_w-1:0] adr,
  input  logic [reg_w-1:0] dat_w,
  output logic [reg_w-1:0] dat_r,
  output logic             ack,
  host_chan_if.regs        req,
  host_chan_if.regs        rep
);
  logic             access;  // new cycle, not the ack beat
  logic             rd;
  logic             wr;
  logic [reg_w-1:0] status;

  assign access = cyc && stb && !ack;
  assign rd     = access && !we;
  assign wr     = access && we;

  // strobes act on the same edge that registers ack
  assign req.rx_pop  = rd && (adr == reg_rx_req) && req.rx_valid;  // empty read pops nothing
  assign rep.rx_pop  = rd && (adr == reg_rx_rep) && rep.rx_valid;
  assign req.tx_push = wr && (adr == reg_tx_req) && !req.tx_full;  // full write dropped
  assign rep.tx_push = wr && (adr == reg_tx_rep) && !rep.tx_full;
  assign req.tx_entry = dat_w[entry_w-1:0];
  assign rep.tx_entry = dat_w[entry_w-1:0];

  assign status = {{(reg_w-4){1'b0}},
                   rep.tx_full,          // bit 3
                   req.tx_full,          // bit 2
                   (rep.rx_count != '0), // bit 1
                   (req.rx_count != '0)};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= access;  // single beat
    end
  end

  // read data, frame code lands in 17:16
  always_ff @(posedge clk) begin
    if (rd) begin
      case (adr)
        reg_rx_req: dat_r <= req.rx_valid ? reg_w'(req.rx_entry) : '0;
        reg_rx_rep: dat_r <= rep.rx_valid ? reg_w'(rep.rx_entry) : '0;
        reg_status: dat_r <= status;
        default:    dat_r <= '0;  // tx registers read back zero
      endcase
    end
  end
endmodule

// ==== ring_node.sv ====
`timescale 1ns/100ps
// ring_node
// one node of the two-channel flit ring: request and reply channels,
// the ring link arbiter and the host register block
module ring_node import ring_pkg::*; #(
  parameter int NODE_ID    = 0,
  parameter int FIFO_DEPTH = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ctrl_w-1:0] ctrl_in,        // 00 none, 01 head, 10 body, 11 tail
  input  logic [flit_w-1:0] flit_in,
  input  logic [chan_w-1:0] dest_fifo_in,   // which channel the flit rides
  input  logic              en_pass_req_in, // downstream pass fifos can take
  input  logic              en_pass_rep_in,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [adr_w-1:0]  wb_adr,
  input  logic [reg_w-1:0]  wb_dat_w,
  output logic              en_pass_req,    // to upstream
  output logic              en_pass_rep,
  output logic [ctrl_w-1:0] ctrl_out,
  output logic [flit_w-1:0] flit_out,
  output logic [chan_w-1:0] dest_fifo_out,
  output logic [reg_w-1:0]  wb_dat_r,
  output logic              wb_ack
);
  logic               flit_present;
  logic [entry_w-1:0] in_entry;

  host_chan_if #(.FIFO_DEPTH(FIFO_DEPTH)) req_host ();
  host_chan_if #(.FIFO_DEPTH(FIFO_DEPTH)) rep_host ();
  flit_link_if req_link ();
  flit_link_if rep_link ();

  assign flit_present = (ctrl_in != ctrl_none);
  assign in_entry     = {ctrl_in, flit_in};

  // ring input split by channel tag
  ring_channel #(.NODE_ID(NODE_ID), .FIFO_DEPTH(FIFO_DEPTH)) req_chan (
    .clk(clk), .rst_n(rst_n),
    .in_valid(flit_present && (dest_fifo_in == chan_req)),
    .in_entry(in_entry), .in_ready(en_pass_req),
    .host(req_host.chan), .link(req_link.src)
  );

  ring_channel #(.NODE_ID(NODE_ID), .FIFO_DEPTH(FIFO_DEPTH)) rep_chan (
    .clk(clk), .rst_n(rst_n),
    .in_valid(flit_present && (dest_fifo_in == chan_rep)),
    .in_entry(in_entry), .in_ready(en_pass_rep),
    .host(rep_host.chan), .link(rep_link.src)
  );

  link_arbiter link_arb (
    .clk(clk), .rst_n(rst_n),
    .req_ready(en_pass_req_in), .rep_ready(en_pass_rep_in),
    .req(req_link.sink), .rep(rep_link.sink),
    .ctrl_out(ctrl_out), .flit_out(flit_out), .dest_fifo_out(dest_fifo_out)
  );

  node_regs regs (
    .clk(clk), .rst_n(rst_n),
    .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr), .dat_w(wb_dat_w),
    .dat_r(wb_dat_r), .ack(wb_ack),
    .req(req_host.regs), .rep(rep_host.regs)
  );
endmodule

// ==== ring_node_props.sv ====
`timescale 1ns/100ps
// ring node properties
// ring output respects downstream ready, ack follows a bus request,
// and a packet keeps one channel tag from head to tail
module ring_node_props import ring_pkg::*; (
  input logic              clk,
  input logic              rst_n,
  input logic [ctrl_w-1:0] ctrl_out,
  input logic [chan_w-1:0] dest_fifo_out,
  input logic              en_pass_req_in,
  input logic              en_pass_rep_in,
  input logic              wb_cyc,
  input logic              wb_stb,
  input logic              wb_ack
);
  logic              in_pkt;    // between a head and its tail on the output
  logic [chan_w-1:0] pkt_chan;  // tag seen with the head

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_pkt   <= 1'b0;
      pkt_chan <= chan_req;
    end else if (ctrl_out == ctrl_head) begin
      in_pkt   <= 1'b1;
      pkt_chan <= dest_fifo_out;
    end else if (ctrl_out == ctrl_tail) begin
      in_pkt   <= 1'b0;
    end
  end

  req_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
    (ctrl_out != ctrl_none && dest_fifo_out == chan_req) |-> en_pass_req_in)
    else $error("request flit sent while downstream request channel not ready");

  rep_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
    (ctrl_out != ctrl_none && dest_fifo_out == chan_rep) |-> en_pass_rep_in)
    else $error("reply flit sent while downstream reply channel not ready");

  ack_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else $error("wishbone ack without a preceding cyc and stb");

  chan_a: assert property (@(posedge clk) disable iff (!rst_n)
    in_pkt |-> (dest_fifo_out == pkt_chan))
    else $error("dest_fifo_out changed inside a packet");
endmodule

bind ring_node ring_node_props props (
  .clk(clk), .rst_n(rst_n),
  .ctrl_out(ctrl_out), .dest_fifo_out(dest_fifo_out),
  .en_pass_req_in(en_pass_req_in), .en_pass_rep_in(en_pass_rep_in),
  .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack)
);

// ==== tb_ring_node.sv ====
`timescale 1ns/100ps
// testbench for the ring node
// replays the stimulus file through a ring driver and a wishbone host driver,
// a monitor collects ring output flits per channel for the out checks
module tb_ring_node import ring_pkg::*; ();
  localparam string stim_file = "ring_stimulus.txt";

  logic               clk = 1'b0;
  logic               rst_n;
  logic [ctrl_w-1:0]  ctrl_in;
  logic [flit_w-1:0]  flit_in;
  logic [chan_w-1:0]  dest_fifo_in;
  logic               en_pass_req_in = 1'b1;  // downstream ready, pulled low by stalls
  logic               en_pass_rep_in = 1'b1;
  logic               wb_cyc;
  logic               wb_stb;
  logic               wb_we;
  logic [adr_w-1:0]   wb_adr;
  logic [reg_w-1:0]   wb_dat_w;
  logic               en_pass_req;
  logic               en_pass_rep;
  logic [ctrl_w-1:0]  ctrl_out;
  logic [flit_w-1:0]  flit_out;
  logic [chan_w-1:0]  dest_fifo_out;
  logic [reg_w-1:0]   wb_dat_r;
  logic               wb_ack;

  logic [entry_w-1:0] req_q[$];       // ring output, filled by the monitor
  logic [entry_w-1:0] rep_q[$];
  int                 req_rd = 0;     // next unchecked entry
  int                 rep_rd = 0;
  int                 cycle_count = 0;
  int                 cycle_limit = 200;
  int                 req_stall_end = 0;
  int                 rep_stall_end = 0;
  logic               mid_pkt = 1'b0;  // output is inside a packet
  logic [chan_w-1:0]  mid_chan = chan_req;

  ring_node #(.NODE_ID(3), .FIFO_DEPTH(8)) uut (.*);

  always #5 clk = ~clk;

  // cycle count, downstream ready windows and the run limit
  always @(posedge clk) begin
    cycle_count    <= cycle_count + 1;
    en_pass_req_in <= (cycle_count >= req_stall_end);
    en_pass_rep_in <= (cycle_count >= rep_stall_end);
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  // a flit on ctrl_out at the falling edge leaves on the next rising edge
  always @(negedge clk) begin
    if (rst_n && ctrl_out != ctrl_none) begin
      if (mid_pkt) begin
        check_value("dest_fifo_out", 32'(dest_fifo_out), 32'(mid_chan));  // no interleave
      end
      if (dest_fifo_out == chan_req) begin
        check_value("en_pass_req_in", 32'(en_pass_req_in), 32'd1);
        req_q.push_back({ctrl_out, flit_out});
      end else begin
        check_value("en_pass_rep_in", 32'(en_pass_rep_in), 32'd1);
        rep_q.push_back({ctrl_out, flit_out});
      end
      mid_pkt  = (ctrl_out != ctrl_tail);
      mid_chan = dest_fifo_out;
    end
  end

  task automatic open_stimulus(output int fd);
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", stim_file);
      $display("TEST FAILED");
      $fatal(1, "no stimulus");
    end
  endtask

  task automatic skip_line(input int fd);
    logic [8*128-1:0] rest;
    void'($fgets(rest, fd));
  endtask

  // first pass over the file, comment lines start with #
  task automatic count_commands(output int total);
    int          fd;
    logic [63:0] word;
    total = 0;
    open_stimulus(fd);
    while ($fscanf(fd, "%s", word) == 1) begin
      if (word != "#") total++;
      skip_line(fd);
    end
    $fclose(fd);
  endtask

  // one wishbone classic access, no wait states expected
  task automatic bus_access(input logic write, input logic [adr_w-1:0] adr,
                            input logic [reg_w-1:0] data, output logic [reg_w-1:0] rdata);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= write;
    wb_adr   <= adr;
    wb_dat_w <= data;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  // one ring flit, presented only while that channel's pass enable is high
  task automatic send_flit(input logic [chan_w-1:0] ch, input logic [entry_w-1:0] entry);
    @(negedge clk);
    while (!(ch == chan_req ? en_pass_req : en_pass_rep)) @(negedge clk);
    @(posedge clk);
    ctrl_in      <= entry[entry_w-1 -: ctrl_w];
    flit_in      <= entry[flit_w-1:0];
    dest_fifo_in <= ch;
    @(posedge clk);
    ctrl_in <= ctrl_none;  // taken on this edge
  endtask

  initial begin
    int                 fd;
    int                 n;
    logic [31:0]        ch;
    logic [31:0]        val;
    logic [reg_w-1:0]   rdata;
    logic [entry_w-1:0] got;
    logic [63:0]        cmd;
    void'($urandom(32'hcf9b));
    rst_n        = 1'b0;
    ctrl_in      = ctrl_none;
    flit_in      = '0;
    dest_fifo_in = '0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    count_commands(n);
    cycle_limit = 200 + 40 * n;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("en_pass_req", 32'(en_pass_req), 32'd1);  // all fifos empty out of reset
    check_value("en_pass_rep", 32'(en_pass_rep), 32'd1);
    check_value("ctrl_out", 32'(ctrl_out), 32'(ctrl_none));
    check_value("wb_ack", 32'(wb_ack), 32'd0);
    open_stimulus(fd);
    while ($fscanf(fd, "%s", cmd) == 1) begin
      case (cmd)
        "#": skip_line(fd);
        "ring": begin
          void'($fscanf(fd, "%d %d", ch, n));
          for (int i = 0; i < n; i++) begin
            void'($fscanf(fd, "%h", val));
            send_flit(ch[chan_w-1:0], val[entry_w-1:0]);
          end
        end
        "tx": begin
          void'($fscanf(fd, "%d %d", ch, n));
          for (int i = 0; i < n; i++) begin
            void'($fscanf(fd, "%h", val));
            bus_access(1'b1, (ch == 1) ? reg_tx_req : reg_tx_rep, val, rdata);
          end
        end
        "rx": begin
          void'($fscanf(fd, "%d %d", ch, n));
          for (int i = 0; i < n; i++) begin
            void'($fscanf(fd, "%h", val));
            bus_access(1'b0, (ch == 1) ? reg_rx_req : reg_rx_rep, '0, rdata);
            check_value("wb_dat_r", rdata, val);
          end
        end
        "out": begin
          void'($fscanf(fd, "%d %d", ch, n));
          while (((ch == 1) ? req_q.size() - req_rd : rep_q.size() - rep_rd) < n) begin
            @(negedge clk);
          end
          for (int i = 0; i < n; i++) begin
            void'($fscanf(fd, "%h", val));
            if (ch == 1) begin
              got = req_q[req_rd];
              req_rd++;
            end else begin
              got = rep_q[rep_rd];
              rep_rd++;
            end
            check_value((ch == 1) ? "ring out req flit" : "ring out rep flit", 32'(got), val);
          end
        end
        "stall": begin
          void'($fscanf(fd, "%d %d", ch, n));
          @(negedge clk);
          if (ch == 1) req_stall_end = cycle_count + n + int'($urandom_range(3, 0));
          else rep_stall_end = cycle_count + n + int'($urandom_range(3, 0));
        end
        "status": begin
          void'($fscanf(fd, "%h", val));
          bus_access(1'b0, reg_status, '0, rdata);
          check_value("status", rdata, val);
        end
        default: begin
          $display("unknown command in the stimulus file");
          $display("TEST FAILED");
          $fatal(1, "bad stimulus");
        end
      endcase
    end
    $fclose(fd);
    repeat (20) @(negedge clk);  // stray flits would show up by now
    check_value("extra req output flits", 32'(req_q.size() - req_rd), 32'd0);
    check_value("extra rep output flits", 32'(rep_q.size() - rep_rd), 32'd0);
    $display("TEST PASSED");
    $finish;
  end
endmodule

// ==== build.f ====
ring_pkg.sv
ring_ifs.sv
flit_fifo.sv
ring_channel.sv
link_arbiter.sv
node_regs.sv
ring_node.sv
ring_node_props.sv
tb_ring_node.sv

// ==== Makefile ====
# Verilator build, run and lint for the ring node testbench
VERILATOR ?= verilator
TOP       ?= tb_ring_node
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
STIMULUS  ?= ring_stimulus.txt
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, the simulator exit code is not trusted
run: $(BIN) $(STIMULUS)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== ring_stimulus.txt ====
# one command per line; chan 1 is request, 2 is reply; counts and cycles decimal
# ring|tx|rx|out <chan> <count> <entries>   stall <chan> <cycles>   status <value>
# entries hex: frame code digit (1 head, 2 body, 3 tail) then the 16-bit flit
status 0
rx 1 1 0
ring 1 3 13a51 2beef 3cafe
status 1
rx 1 3 13a51 2beef 3cafe
status 0
rx 1 1 0
ring 1 2 15312 30042
out 1 2 15312 30042
ring 2 3 17344 21111 32222
out 2 3 17344 21111 32222
tx 1 3 16301 2aaaa 3bbbb
out 1 3 16301 2aaaa 3bbbb
tx 2 2 18302 3cccc
out 2 2 18302 3cccc
stall 1 30
tx 1 2 19303 3dddd
ring 1 3 1a213 2e0e0 3f0f0
out 1 5 1a213 2e0e0 3f0f0 19303 3dddd
stall 2 40
ring 2 4 1b214 20101 20202 30303
tx 2 2 1c304 3eeee
ring 1 2 1d215 30404
out 1 2 1d215 30404
out 2 6 1b214 20101 20202 30303 1c304 3eeee
status 0
